// File: pkt_buf_top.f
hdl/pkt_buf_pkg.sv
hdl/page_check_gen.sv
hdl/page_free_queue.sv
hdl/page_store.sv
hdl/pkt_writer.sv
hdl/pkt_reader.sv
hdl/pkt_buf_top.sv
verification/pkt_buf_chk.sv
verification/tb_pkt_buf.sv

// File: Makefile
SIM      ?= verilator
FLAGS    ?= --binary --timing --assert -Wno-fatal
TOP      ?= tb_pkt_buf
FILELIST ?= pkt_buf_top.f
OBJ_DIR  ?= obj_dir
LOG      ?= sim.log
RUN_ARGS ?= +verilator+error+limit+1000

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Test FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "Test OK" $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: verification/tb_pkt_buf.sv
`timescale 1ns/1ps

module tb_pkt_buf;
    import pkt_buf_pkg::*;

    localparam int ROUNDS    = 6;
    localparam int PKTS      = 8;
    localparam int MAX_PAGES = 5;
    localparam int MAX_WORDS = MAX_PAGES * PAGE_WORDS;
    localparam int TIMEOUT   = 2000;

    logic      clk;
    logic      rst_n;
    logic      wr_vld;
    word_t     wr_data;
    logic      wr_eop;
    logic      rd_start;
    page_t     rd_head;
    pcnt_t     rd_pages;
    logic      desc_vld;
    pkt_desc_t desc;
    logic      rd_vld;
    word_t     rd_data;
    code_t     rd_code;
    logic      rd_done;
    fcnt_t     free_pages;
    logic      ready;

    // marks the header halfword on the write bus
    logic      hdr_cyc;

    int seed   = 32'hdd15;
    int errors = 0;

    word_t pkt_mem [PKTS][MAX_WORDS];
    int    pkt_len [PKTS];

    // expected and captured traffic
    pkt_desc_t exp_desc_q [$];
    pkt_desc_t got_desc_q [$];
    word_t     exp_word_q [$];
    logic      exp_care_q [$];
    code_t     exp_code_q [$];

    // compare process state
    logic hdr_prev;
    logic rd_busy;
    int   rd_age;
    int   rd_len;
    int   desc_seen = 0;

    pkt_buf_top i_pkt_buf_top (
        .clk        (clk),
        .rst_n      (rst_n),
        .wr_vld     (wr_vld),
        .wr_data    (wr_data),
        .wr_eop     (wr_eop),
        .rd_start   (rd_start),
        .rd_head    (rd_head),
        .rd_pages   (rd_pages),
        .desc_vld   (desc_vld),
        .desc       (desc),
        .rd_vld     (rd_vld),
        .rd_data    (rd_data),
        .rd_code    (rd_code),
        .rd_done    (rd_done),
        .free_pages (free_pages),
        .ready      (ready)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic int pkt_pages(int p);
        return (pkt_len[p] + PAGE_WORDS - 1) / PAGE_WORDS;
    endfunction

    // xor of low and high byte over the page, missing words count as zero
    function automatic code_t page_code(int p, int pg);
        code_t c;
        word_t w;
        int    idx;
        c = '0;
        for (int s = 0; s < PAGE_WORDS; s++) begin
            idx = pg * PAGE_WORDS + s;
            w   = (idx < pkt_len[p]) ? pkt_mem[p][idx] : '0;
            c   = c ^ w[7:0] ^ w[15:8];
        end
        return c;
    endfunction

    task automatic compare_value(string name, int unsigned got, int unsigned exp);
        assert (got == exp) else begin
            errors++;
            $display("Fail %0t %s expected %0h got %0h", $time, name, exp, got);
        end
    endtask

    task automatic finish_run();
        int unsigned chk_errors;
        chk_errors = i_pkt_buf_top.i_pkt_buf_chk.fail_cnt;
        $display("errors: %0d testbench, %0d assertion", errors, chk_errors);
        if (errors == 0 && chk_errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    endtask

    task automatic stop_on_timeout(string what);
        errors++;
        $display("timeout while waiting for %s", what);
        finish_run();
    endtask

    // random lengths, header carries page count, priority and port
    task automatic make_packets();
        for (int p = 0; p < PKTS; p++) begin
            pkt_len[p] = 1 + int'($unsigned($random(seed)) % MAX_WORDS);
            for (int i = 0; i < MAX_WORDS; i++) begin
                pkt_mem[p][i] = word_t'($random(seed));
            end
            pkt_mem[p][0][15:10] = 6'(pkt_pages(p) - 1);
        end
    endtask

    task automatic send_packet(int p);
        pkt_desc_t d;
        int        gap;
        d.dest  = pkt_mem[p][0][3:0];
        d.prior = pkt_mem[p][0][6:4];
        d.head  = '0;
        d.pages = pcnt_t'(pkt_pages(p));
        exp_desc_q.push_back(d);
        for (int i = 0; i < pkt_len[p]; i++) begin
            @(negedge clk);
            wr_vld  = 1'b1;
            wr_data = pkt_mem[p][i];
            hdr_cyc = (i == 0);
        end
        @(negedge clk);
        wr_vld  = 1'b0;
        hdr_cyc = 1'b0;
        wr_eop  = 1'b1;
        @(negedge clk);
        wr_eop = 1'b0;
        // idle gap between packets
        gap = int'($unsigned($random(seed)) % 3);
        repeat (gap) @(negedge clk);
    endtask

    task automatic read_packet(int p);
        pkt_desc_t d;
        int        idx;
        int        n;
        d = got_desc_q.pop_front();
        // padding words beyond the packet are don't care
        for (int pg = 0; pg < int'(d.pages); pg++) begin
            for (int s = 0; s < PAGE_WORDS; s++) begin
                idx = pg * PAGE_WORDS + s;
                exp_care_q.push_back(idx < pkt_len[p]);
                exp_word_q.push_back((idx < pkt_len[p]) ? pkt_mem[p][idx] : '0);
                exp_code_q.push_back(page_code(p, pg));
            end
        end
        @(negedge clk);
        rd_start = 1'b1;
        rd_head  = d.head;
        rd_pages = d.pages;
        @(negedge clk);
        rd_start = 1'b0;
        n = 0;
        while (!rd_done) begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT) stop_on_timeout("rd_done");
        end
    endtask

    task automatic wait_ready();
        int n;
        n = 0;
        while (!ready) begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT) stop_on_timeout("ready");
        end
    endtask

    task automatic wait_descs();
        int n;
        n = 0;
        while (got_desc_q.size() < PKTS) begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT) stop_on_timeout("desc_vld");
        end
    endtask

    // samples at the rising edge, values of the cycle just ended
    always @(posedge clk) begin : compare_outputs
        pkt_desc_t exp_d;
        logic      exp_vld;
        logic      exp_done;
        if (!rst_n) begin
            hdr_prev = 1'b0;
            rd_busy  = 1'b0;
        end else begin
            // descriptor exactly one cycle after the header
            compare_value("desc_vld", desc_vld, hdr_prev);
            if (desc_vld) begin
                assert (exp_desc_q.size() != 0) else begin
                    errors++;
                    $display("descriptor arrived with none expected at %0t", $time);
                end
                if (exp_desc_q.size() != 0) begin
                    exp_d = exp_desc_q.pop_front();
                    compare_value("desc.dest", desc.dest, exp_d.dest);
                    compare_value("desc.prior", desc.prior, exp_d.prior);
                    compare_value("desc.pages", desc.pages, exp_d.pages);
                    // in-order self-fill, first packet gets page 0
                    if (desc_seen == 0) compare_value("desc.head", desc.head, 0);
                    desc_seen++;
                    got_desc_q.push_back(desc);
                end
            end
            hdr_prev = wr_vld && hdr_cyc;

            // read stream 2 cycles after start, no gaps, then done
            if (rd_busy) rd_age++;
            exp_vld  = rd_busy && rd_age >= 2 && rd_age < 2 + rd_len;
            exp_done = rd_busy && rd_age == 2 + rd_len;
            compare_value("rd_vld", rd_vld, exp_vld);
            compare_value("rd_done", rd_done, exp_done);
            if (exp_done) rd_busy = 1'b0;
            if (rd_vld) begin
                assert (exp_word_q.size() != 0) else begin
                    errors++;
                    $display("read word arrived with none expected at %0t", $time);
                end
                if (exp_word_q.size() != 0) begin
                    if (exp_care_q.pop_front()) begin
                        compare_value("rd_data", rd_data, exp_word_q[0]);
                    end
                    void'(exp_word_q.pop_front());
                    compare_value("rd_code", rd_code, exp_code_q.pop_front());
                end
            end
            if (rd_start) begin
                rd_busy = 1'b1;
                rd_age  = 0;
                rd_len  = PAGE_WORDS * int'(rd_pages);
            end
        end
    end

    initial begin : stimulus
        int round_pages;
        rst_n    = 1'b0;
        wr_vld   = 1'b0;
        wr_data  = '0;
        wr_eop   = 1'b0;
        hdr_cyc  = 1'b0;
        rd_start = 1'b0;
        rd_head  = '0;
        rd_pages = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        // fill has not started yet
        compare_value("ready", ready, 0);

        // self-fill
        wait_ready();
        @(negedge clk);
        compare_value("free_pages", free_pages, PAGE_CNT);

        // rounds add up to more pages than the buffer holds
        for (int r = 0; r < ROUNDS; r++) begin
            make_packets();
            round_pages = 0;
            for (int p = 0; p < PKTS; p++) begin
                send_packet(p);
                round_pages += pkt_pages(p);
                // every page of this packet popped by now
                compare_value("free_pages", free_pages, PAGE_CNT - round_pages);
            end
            wait_descs();
            for (int p = 0; p < PKTS; p++) begin
                read_packet(p);
            end
            @(negedge clk);
            compare_value("free_pages", free_pages, PAGE_CNT);
        end
        repeat (4) @(negedge clk);
        finish_run();
    end

endmodule

// File: verification/pkt_buf_chk.sv
`timescale 1ns/1ps

module pkt_buf_chk (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                wr_vld,
    input  pkt_buf_pkg::word_t  wr_data,
    input  logic                wr_eop,
    input  logic                rd_start,
    input  logic                rd_vld,
    input  logic                rd_done,
    input  logic                desc_vld,
    input  logic                ready,
    input  pkt_buf_pkg::fcnt_t  free_pages
);
    import pkt_buf_pkg::*;

    // failed assertions, read back by the testbench
    int unsigned fail_cnt = 0;

    logic in_pkt;
    logic rd_busy;
    logic hdr;

    // header is the first halfword outside a packet
    assign hdr = wr_vld && !in_pkt;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            in_pkt  <= 1'b0;
            rd_busy <= 1'b0;
        end else begin
            if (wr_eop) begin
                in_pkt <= 1'b0;
            end else if (wr_vld) begin
                in_pkt <= 1'b1;
            end
            if (rd_start) begin
                rd_busy <= 1'b1;
            end else if (rd_done) begin
                rd_busy <= 1'b0;
            end
        end
    end

    // eop is its own strobe
    eop_alone: assert property (@(posedge clk) disable iff (!rst_n)
        !(wr_vld && wr_eop))
        else begin fail_cnt++; $error("wr_eop together with wr_vld"); end

    // no writes before self-fill ends
    wr_after_ready: assert property (@(posedge clk) disable iff (!rst_n)
        wr_vld |-> ready)
        else begin fail_cnt++; $error("write before ready"); end

    // packet must fit into the free pages
    enough_pages: assert property (@(posedge clk) disable iff (!rst_n)
        hdr |-> (free_pages > fcnt_t'(wr_data[15:10])))
        else begin fail_cnt++; $error("packet larger than free pages"); end

    desc_after_hdr: assert property (@(posedge clk) disable iff (!rst_n)
        hdr |=> desc_vld)
        else begin fail_cnt++; $error("no descriptor after header"); end

    // one read at a time
    no_read_overlap: assert property (@(posedge clk) disable iff (!rst_n)
        rd_start |-> (!rd_busy || rd_done))
        else begin fail_cnt++; $error("read started while busy"); end

    read_latency: assert property (@(posedge clk) disable iff (!rst_n)
        (rd_vld && !$past(rd_vld)) |-> $past(rd_start, 2))
        else begin fail_cnt++; $error("first read word not 2 cycles after start"); end

    free_in_range: assert property (@(posedge clk) disable iff (!rst_n)
        free_pages <= fcnt_t'(PAGE_CNT))
        else begin fail_cnt++; $error("free page count above buffer size"); end

endmodule

bind pkt_buf_top pkt_buf_chk i_pkt_buf_chk (
    .clk        (clk),
    .rst_n      (rst_n),
    .wr_vld     (wr_vld),
    .wr_data    (wr_data),
    .wr_eop     (wr_eop),
    .rd_start   (rd_start),
    .rd_vld     (rd_vld),
    .rd_done    (rd_done),
    .desc_vld   (desc_vld),
    .ready      (ready),
    .free_pages (free_pages)
);

// File: hdl/pkt_buf_top.sv
`timescale 1ns/1ps

module pkt_buf_top (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    wr_vld,
    input  pkt_buf_pkg::word_t      wr_data,
    input  logic                    wr_eop,
    input  logic                    rd_start,
    input  pkt_buf_pkg::page_t      rd_head,
    input  pkt_buf_pkg::pcnt_t      rd_pages,
    output logic                    desc_vld,
    output pkt_buf_pkg::pkt_desc_t  desc,
    output logic                    rd_vld,
    output pkt_buf_pkg::word_t      rd_data,
    output pkt_buf_pkg::code_t      rd_code,
    output logic                    rd_done,
    output pkt_buf_pkg::fcnt_t      free_pages,
    output logic                    ready
);
    import pkt_buf_pkg::*;

    // free queue
    logic  pop;
    logic  push;
    page_t head_page;
    page_t push_page;

    // writer side of the store
    logic  data_we;
    page_t data_addr;
    slot_t data_slot;
    word_t data_din;
    logic  link_we;
    page_t link_addr;
    page_t link_din;
    logic  code_we;
    page_t code_addr;
    code_t code_din;

    // reader side of the store
    page_t st_rd_page;
    slot_t st_rd_slot;
    word_t st_rd_word;
    page_t st_rd_link;
    code_t st_rd_code;

    pkt_writer i_pkt_writer (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr_vld    (wr_vld),
        .wr_data   (wr_data),
        .wr_eop    (wr_eop),
        .head_page (head_page),
        .pop       (pop),
        .data_we   (data_we),
        .data_addr (data_addr),
        .data_slot (data_slot),
        .data_din  (data_din),
        .link_we   (link_we),
        .link_addr (link_addr),
        .link_din  (link_din),
        .code_we   (code_we),
        .code_addr (code_addr),
        .code_din  (code_din),
        .desc_vld  (desc_vld),
        .desc      (desc)
    );

    pkt_reader i_pkt_reader (
        .clk        (clk),
        .rst_n      (rst_n),
        .rd_start   (rd_start),
        .rd_head    (rd_head),
        .rd_pages   (rd_pages),
        .rd_page    (st_rd_page),
        .rd_slot    (st_rd_slot),
        .rd_word    (st_rd_word),
        .rd_link    (st_rd_link),
        .rd_code_in (st_rd_code),
        .push       (push),
        .push_page  (push_page),
        .rd_vld     (rd_vld),
        .rd_data    (rd_data),
        .rd_code    (rd_code),
        .rd_done    (rd_done)
    );

    page_free_queue i_page_free_queue (
        .clk        (clk),
        .rst_n      (rst_n),
        .pop        (pop),
        .push       (push),
        .push_page  (push_page),
        .head_page  (head_page),
        .free_pages (free_pages),
        .ready      (ready)
    );

    page_store i_page_store (
        .clk       (clk),
        .data_we   (data_we),
        .data_addr (data_addr),
        .data_slot (data_slot),
        .data_din  (data_din),
        .link_we   (link_we),
        .link_addr (link_addr),
        .link_din  (link_din),
        .code_we   (code_we),
        .code_addr (code_addr),
        .code_din  (code_din),
        .rd_page   (st_rd_page),
        .rd_slot   (st_rd_slot),
        .rd_word   (st_rd_word),
        .rd_link   (st_rd_link),
        .rd_code   (st_rd_code)
    );

endmodule

// File: hdl/pkt_reader.sv
`timescale 1ns/1ps

module pkt_reader (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                rd_start,
    input  pkt_buf_pkg::page_t  rd_head,
    input  pkt_buf_pkg::pcnt_t  rd_pages,
    output pkt_buf_pkg::page_t  rd_page,
    output pkt_buf_pkg::slot_t  rd_slot,
    input  pkt_buf_pkg::word_t  rd_word,
    input  pkt_buf_pkg::page_t  rd_link,
    input  pkt_buf_pkg::code_t  rd_code_in,
    output logic                push,
    output pkt_buf_pkg::page_t  push_page,
    output logic                rd_vld,
    output pkt_buf_pkg::word_t  rd_data,
    output pkt_buf_pkg::code_t  rd_code,
    output logic                rd_done
);
    import pkt_buf_pkg::*;

    logic  active;
    slot_t slot;
    page_t page;
    page_t link_q;
    pcnt_t remain;
    logic  page_last;

    assign page_last = active && (slot == LAST_SLOT);

    // address phase, one halfword per cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            active <= 1'b0;
            slot   <= '0;
            remain <= '0;
        end else if (rd_start) begin
            active <= 1'b1;
            slot   <= '0;
            remain <= rd_pages;
        end else if (active) begin
            slot <= slot + 1'b1;
            if (slot == LAST_SLOT) begin
                // remain counts the page being read
                if (remain == pcnt_t'(1)) begin
                    active <= 1'b0;
                end
                remain <= remain - 1'b1;
            end
        end
    end

    // rd_link is valid for the current page from slot 1 on
    always_ff @(posedge clk) begin
        if (active && slot == LINK_SLOT) begin
            link_q <= rd_link;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_start) begin
            page <= rd_head;
        end else if (page_last) begin
            page <= link_q;
        end
    end

    // valid lags the address by the memory latency
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_vld  <= 1'b0;
            rd_done <= 1'b0;
        end else begin
            rd_vld  <= active;
            rd_done <= rd_vld && !active;
        end
    end

    assign rd_page   = page;
    assign rd_slot   = slot;

    // page returns to the free queue on its last read
    assign push      = page_last;
    assign push_page = page;

    // code read follows the page address, same latency as data
    assign rd_data   = rd_word;
    assign rd_code   = rd_code_in;

endmodule

// File: hdl/pkt_writer.sv
`timescale 1ns/1ps

module pkt_writer (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    wr_vld,
    input  pkt_buf_pkg::word_t      wr_data,
    input  logic                    wr_eop,
    input  pkt_buf_pkg::page_t      head_page,
    output logic                    pop,
    output logic                    data_we,
    output pkt_buf_pkg::page_t      data_addr,
    output pkt_buf_pkg::slot_t      data_slot,
    output pkt_buf_pkg::word_t      data_din,
    output logic                    link_we,
    output pkt_buf_pkg::page_t      link_addr,
    output pkt_buf_pkg::page_t      link_din,
    output logic                    code_we,
    output pkt_buf_pkg::page_t      code_addr,
    output pkt_buf_pkg::code_t      code_din,
    output logic                    desc_vld,
    output pkt_buf_pkg::pkt_desc_t  desc
);
    import pkt_buf_pkg::*;

    wr_state_t               state;
    slot_t                   slot;
    page_t                   cur_page;
    page_t                   next_page;
    page_t                   page_now;
    logic                    page_start;
    logic                    page_end;
    logic                    pop_q1;
    logic                    pop_q2;
    word_t [PAGE_WORDS-1:0]  chk_buf;
    logic [PAGE_AW:0]        pages_raw;

    assign page_start = wr_vld && (slot == '0);
    // eop right after slot 7 leaves slot at 0, that page already ended
    assign page_end   = (wr_vld && slot == LAST_SLOT) || (wr_eop && slot != '0);

    // first page straight from the queue head, later ones from lookahead
    assign page_now = !page_start             ? cur_page  :
                      (state == next_pages)   ? next_page : head_page;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= idle;
        end else begin
            case (state)
                idle:       if (wr_vld) state <= first_page;
                first_page: begin
                    if (wr_eop) begin
                        state <= idle;
                    end else if (wr_vld && slot == LAST_SLOT) begin
                        state <= next_pages;
                    end
                end
                next_pages: if (wr_eop) state <= idle;
                default:    state <= idle;
            endcase
        end
    end

    // slot index, back to 0 at packet end
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            slot <= '0;
        end else if (wr_eop) begin
            slot <= '0;
        end else if (wr_vld) begin
            slot <= slot + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (page_start) begin
            cur_page <= page_now;
        end
    end

    // head_page shows the next free page two cycles after a pop
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pop_q1 <= 1'b0;
            pop_q2 <= 1'b0;
        end else begin
            pop_q1 <= pop;
            pop_q2 <= pop_q1;
        end
    end

    always_ff @(posedge clk) begin
        if (pop_q2) begin
            next_page <= head_page;
        end
    end

    // page copy for the check code, cleared for zero padding
    always_ff @(posedge clk) begin
        if (wr_vld) begin
            if (slot == '0) begin
                chk_buf <= '0;
            end
            chk_buf[slot] <= wr_data;
        end
    end

    // code goes out once the buffer holds the whole page
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            code_we <= 1'b0;
        end else begin
            code_we <= page_end;
        end
    end

    always_ff @(posedge clk) begin
        if (page_end) begin
            code_addr <= cur_page;
        end
    end

    page_check_gen i_page_check_gen (
        .words (chk_buf),
        .code  (code_din)
    );

    // header bits 15..10 carry page count minus one
    assign pages_raw = {1'b0, wr_data[15:10]} + 1'b1;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            desc_vld <= 1'b0;
        end else begin
            desc_vld <= wr_vld && (state == idle);
        end
    end

    always_ff @(posedge clk) begin
        if (wr_vld && state == idle) begin
            desc.dest  <= wr_data[3:0];
            desc.prior <= wr_data[6:4];
            desc.head  <= head_page;
            // saturate instead of wrapping to zero
            desc.pages <= pages_raw[PAGE_AW] ? '1 : pages_raw[PAGE_AW-1:0];
        end
    end

    assign pop       = page_start;
    assign data_we   = wr_vld;
    assign data_addr = page_now;
    assign data_slot = slot;
    assign data_din  = wr_data;

    // link from the page just filled to the one starting now
    assign link_we   = page_start && (state == next_pages);
    assign link_addr = cur_page;
    assign link_din  = next_page;

endmodule

// File: hdl/page_store.sv
`timescale 1ns/1ps

module page_store (
    input  logic                clk,
    // writer data port
    input  logic                data_we,
    input  pkt_buf_pkg::page_t  data_addr,
    input  pkt_buf_pkg::slot_t  data_slot,
    input  pkt_buf_pkg::word_t  data_din,
    // writer link port
    input  logic                link_we,
    input  pkt_buf_pkg::page_t  link_addr,
    input  pkt_buf_pkg::page_t  link_din,
    // writer code port
    input  logic                code_we,
    input  pkt_buf_pkg::page_t  code_addr,
    input  pkt_buf_pkg::code_t  code_din,
    // reader port
    input  pkt_buf_pkg::page_t  rd_page,
    input  pkt_buf_pkg::slot_t  rd_slot,
    output pkt_buf_pkg::word_t  rd_word,
    output pkt_buf_pkg::page_t  rd_link,
    output pkt_buf_pkg::code_t  rd_code
);
    import pkt_buf_pkg::*;

    word_t data_mem [PAGE_CNT * PAGE_WORDS];
    page_t link_mem [PAGE_CNT];
    code_t code_mem [PAGE_CNT];

    // halfword address is page then slot
    logic [PAGE_AW+SLOT_AW-1:0] wr_word_addr;
    logic [PAGE_AW+SLOT_AW-1:0] rd_word_addr;

    assign wr_word_addr = {data_addr, data_slot};
    assign rd_word_addr = {rd_page, rd_slot};

    // packet data
    always_ff @(posedge clk) begin
        if (data_we) begin
            data_mem[wr_word_addr] <= data_din;
        end
        rd_word <= data_mem[rd_word_addr];
    end

    // next page of each page in a chain
    always_ff @(posedge clk) begin
        if (link_we) begin
            link_mem[link_addr] <= link_din;
        end
        rd_link <= link_mem[rd_page];
    end

    // check code per page
    always_ff @(posedge clk) begin
        if (code_we) begin
            code_mem[code_addr] <= code_din;
        end
        rd_code <= code_mem[rd_page];
    end

endmodule

// File: hdl/page_free_queue.sv
`timescale 1ns/1ps

module page_free_queue (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                pop,
    input  logic                push,
    input  pkt_buf_pkg::page_t  push_page,
    output pkt_buf_pkg::page_t  head_page,
    output pkt_buf_pkg::fcnt_t  free_pages,
    output logic                ready
);
    import pkt_buf_pkg::*;

    localparam fcnt_t FULL = fcnt_t'(PAGE_CNT);

    page_t fifo_mem [PAGE_CNT];
    page_t head_ptr;
    page_t tail_ptr;
    fcnt_t fill_cnt;
    fcnt_t count;
    logic  filling;
    logic  wr_en;
    page_t wr_page;

    // self-fill runs until every page number has been queued once
    assign filling = (fill_cnt != FULL);
    assign ready   = !filling;

    // returned pages win over the fill sequence
    assign wr_en   = push || filling;
    assign wr_page = push ? push_page : page_t'(fill_cnt);

    always_ff @(posedge clk) begin
        if (wr_en) begin
            fifo_mem[tail_ptr] <= wr_page;
        end
    end

    // registered head read, new entry two cycles after a pop
    always_ff @(posedge clk) begin
        head_page <= fifo_mem[head_ptr];
    end

    // pointers wrap by themselves, depth is a power of two
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            head_ptr <= '0;
            tail_ptr <= '0;
            fill_cnt <= '0;
        end else begin
            if (pop) begin
                head_ptr <= head_ptr + 1'b1;
            end
            if (wr_en) begin
                tail_ptr <= tail_ptr + 1'b1;
            end
            // a push stalls the fill for one cycle
            if (filling && !push) begin
                fill_cnt <= fill_cnt + 1'b1;
            end
        end
    end

    // occupancy, simultaneous add and remove cancel
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count <= '0;
        end else begin
            case ({wr_en, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign free_pages = count;

endmodule

// File: hdl/page_check_gen.sv
`timescale 1ns/1ps

module page_check_gen (
    input  logic [pkt_buf_pkg::PAGE_BITS-1:0] words,
    output pkt_buf_pkg::code_t                code
);
    import pkt_buf_pkg::*;

    // halfword w sits at words[w*WORD_W +: WORD_W], slot 0 lowest
    always_comb begin
        code = '0;
        for (int w = 0; w < PAGE_WORDS; w++) begin
            for (int i = 0; i < CODE_W; i++) begin
                // low byte bit folded with its high byte partner
                code[i] = code[i]
                        ^ words[w*WORD_W + i]
                        ^ words[w*WORD_W + i + CODE_W];
            end
        end
    end

endmodule

// File: hdl/pkt_buf_pkg.sv
package pkt_buf_pkg;

    // buffer geometry
    localparam int PAGE_CNT   = 64;
    localparam int PAGE_WORDS = 8;
    localparam int WORD_W     = 16;
    localparam int CODE_W     = 8;

    // derived address widths
    localparam int PAGE_AW   = $clog2(PAGE_CNT);
    localparam int SLOT_AW   = $clog2(PAGE_WORDS);
    // one page flattened, as seen by the check generator
    localparam int PAGE_BITS = PAGE_WORDS * WORD_W;

    typedef logic [PAGE_AW-1:0] page_t;
    typedef logic [WORD_W-1:0]  word_t;
    typedef logic [SLOT_AW-1:0] slot_t;
    typedef logic [CODE_W-1:0]  code_t;
    // packet length in pages, saturates at all ones
    typedef logic [PAGE_AW-1:0] pcnt_t;
    // one extra bit so a full queue fits
    typedef logic [PAGE_AW:0]   fcnt_t;

    // last halfword of a page
    localparam slot_t LAST_SLOT = slot_t'(PAGE_WORDS - 1);
    // reader samples the link one slot ahead of the page switch
    localparam slot_t LINK_SLOT = slot_t'(PAGE_WORDS - 2);

    // enqueue descriptor, dest in the top bits
    typedef struct packed {
        logic [3:0] dest;
        logic [2:0] prior;
        page_t      head;
        pcnt_t      pages;
    } pkt_desc_t;

    typedef enum logic [1:0] {
        idle,
        first_page,
        next_pages
    } wr_state_t;

endpackage
